// File: dma_pkg.sv
// DMA engine shared definitions
// Bus widths, table sizes, register map and control bit positions
package dma_pkg;

  localparam int DMA_ADDR_WIDTH = 32;
  localparam int DMA_DATA_WIDTH = 32;
  localparam int DMA_ENTRIES    = 4;
  localparam int DMA_PTR_WIDTH  = 2;
  localparam int DMA_LEN_WIDTH  = 16;
  localparam int DMA_FIFO_DEPTH = 4;

  // Host register map, one 16-byte window per entry
  localparam int DMA_ENTRY_LSB = 4;    // Address bits 5:4 pick the entry
  localparam int DMA_REG_WIDTH = 2;    // Address bits 3:2 pick the register

  localparam logic [3:0] DMA_REG_SRC  = 4'h0;
  localparam logic [3:0] DMA_REG_DST  = 4'h4;
  localparam logic [3:0] DMA_REG_LEN  = 4'h8;
  localparam logic [3:0] DMA_REG_CTRL = 4'hC;

  // CTRL on write
  localparam int DMA_CTRL_START = 0;
  localparam int DMA_CTRL_IEN   = 1;

  // CTRL on read
  localparam int DMA_STAT_VALID = 0;
  localparam int DMA_STAT_IEN   = 1;
  localparam int DMA_STAT_DONE  = 2;

endpackage

// File: dma_cfg_wb.sv
// DMA host configuration port
// Wishbone classic slave that turns host accesses into table writes and reads
`timescale 1ns/1ps

module dma_cfg_wb (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   cfg_cyc_i,
  input  logic                                   cfg_stb_i,
  input  logic                                   cfg_we_i,
  input  logic [dma_pkg::DMA_ADDR_WIDTH-1:0]     cfg_adr_i,
  input  logic [dma_pkg::DMA_DATA_WIDTH-1:0]     cfg_dat_i,
  output logic [dma_pkg::DMA_DATA_WIDTH-1:0]     cfg_dat_o,
  output logic                                   cfg_ack_o,
  output logic                                   tbl_wr_en_o,
  output logic [dma_pkg::DMA_PTR_WIDTH-1:0]      tbl_wr_entry_o,
  output logic [dma_pkg::DMA_REG_WIDTH-1:0]      tbl_wr_reg_o,
  output logic [dma_pkg::DMA_DATA_WIDTH-1:0]     tbl_wr_data_o,
  output logic [dma_pkg::DMA_PTR_WIDTH-1:0]      tbl_rd_entry_o,
  output logic [dma_pkg::DMA_REG_WIDTH-1:0]      tbl_rd_reg_o,
  input  logic [dma_pkg::DMA_DATA_WIDTH-1:0]     tbl_rd_data_i
);
  import dma_pkg::*;

  logic                      ack_q;
  logic [DMA_DATA_WIDTH-1:0] rd_data_q;
  logic                      req;

  // New access not yet acknowledged
  assign req = cfg_cyc_i & cfg_stb_i & ~ack_q;

  // Address split
  assign tbl_wr_entry_o = cfg_adr_i[DMA_ENTRY_LSB +: DMA_PTR_WIDTH];
  assign tbl_wr_reg_o   = cfg_adr_i[2 +: DMA_REG_WIDTH];
  assign tbl_rd_entry_o = cfg_adr_i[DMA_ENTRY_LSB +: DMA_PTR_WIDTH];
  assign tbl_rd_reg_o   = cfg_adr_i[2 +: DMA_REG_WIDTH];

  // Table takes the write on the same edge that raises ack
  assign tbl_wr_en_o   = req & cfg_we_i;
  assign tbl_wr_data_o = cfg_dat_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      rd_data_q <= tbl_rd_data_i;    // Valid together with ack
    end
  end

  assign cfg_ack_o = ack_q;
  assign cfg_dat_o = rd_data_q;

  // Host keeps its request up until the ack
  a_req_held: assert property (@(posedge clk) disable iff (rst)
    cfg_ack_o |-> (cfg_cyc_i && cfg_stb_i))
    else $error("Host dropped its request before the ack");

endmodule

// File: dma_request_table.sv
// DMA request table
// Descriptor storage with valid, done and interrupt state per entry
`timescale 1ns/1ps

module dma_request_table (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   tbl_wr_en_i,
  input  logic [dma_pkg::DMA_PTR_WIDTH-1:0]      tbl_wr_entry_i,
  input  logic [dma_pkg::DMA_REG_WIDTH-1:0]      tbl_wr_reg_i,
  input  logic [dma_pkg::DMA_DATA_WIDTH-1:0]     tbl_wr_data_i,
  input  logic [dma_pkg::DMA_PTR_WIDTH-1:0]      tbl_rd_entry_i,
  input  logic [dma_pkg::DMA_REG_WIDTH-1:0]      tbl_rd_reg_i,
  output logic [dma_pkg::DMA_DATA_WIDTH-1:0]     tbl_rd_data_o,
  input  logic [dma_pkg::DMA_PTR_WIDTH-1:0]      ctrl_sel_i,
  output logic [dma_pkg::DMA_ADDR_WIDTH-1:0]     sel_src_o,
  output logic [dma_pkg::DMA_ADDR_WIDTH-1:0]     sel_dst_o,
  output logic [dma_pkg::DMA_LEN_WIDTH-1:0]      sel_len_o,
  output logic [dma_pkg::DMA_ENTRIES-1:0]        valid_o,
  input  logic                                   retire_en_i,
  input  logic [dma_pkg::DMA_PTR_WIDTH-1:0]      retire_entry_i,
  output logic [dma_pkg::DMA_ENTRIES-1:0]        irq_o
);
  import dma_pkg::*;

  logic [DMA_ADDR_WIDTH-1:0] src_q [DMA_ENTRIES];
  logic [DMA_ADDR_WIDTH-1:0] dst_q [DMA_ENTRIES];
  logic [DMA_LEN_WIDTH-1:0]  len_q [DMA_ENTRIES];
  logic [DMA_ENTRIES-1:0]    valid_q;
  logic [DMA_ENTRIES-1:0]    done_q;
  logic [DMA_ENTRIES-1:0]    ien_q;
  logic                      desc_wr;
  logic                      ctrl_wr;

  // Descriptor fields are locked while the entry is queued or running
  assign desc_wr = tbl_wr_en_i & ~valid_q[tbl_wr_entry_i];
  assign ctrl_wr = tbl_wr_en_i & ({tbl_wr_reg_i, 2'b00} == DMA_REG_CTRL);

  always_ff @(posedge clk) begin
    if (desc_wr) begin
      case ({tbl_wr_reg_i, 2'b00})
        DMA_REG_SRC: src_q[tbl_wr_entry_i] <= tbl_wr_data_i;
        DMA_REG_DST: dst_q[tbl_wr_entry_i] <= tbl_wr_data_i;
        DMA_REG_LEN: len_q[tbl_wr_entry_i] <= tbl_wr_data_i[DMA_LEN_WIDTH-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      done_q  <= '0;
      ien_q   <= '0;
    end else begin
      if (ctrl_wr) begin
        ien_q[tbl_wr_entry_i]  <= tbl_wr_data_i[DMA_CTRL_IEN];
        done_q[tbl_wr_entry_i] <= 1'b0;    // Also acks the interrupt
        if (tbl_wr_data_i[DMA_CTRL_START]) begin
          valid_q[tbl_wr_entry_i] <= 1'b1;
        end
      end
      // Retire last so a finished copy always reports done
      if (retire_en_i) begin
        valid_q[retire_entry_i] <= 1'b0;
        done_q[retire_entry_i]  <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Host readback
  always_comb begin
    tbl_rd_data_o = '0;
    case ({tbl_rd_reg_i, 2'b00})
      DMA_REG_SRC: tbl_rd_data_o = src_q[tbl_rd_entry_i];
      DMA_REG_DST: tbl_rd_data_o = dst_q[tbl_rd_entry_i];
      DMA_REG_LEN: tbl_rd_data_o[DMA_LEN_WIDTH-1:0] = len_q[tbl_rd_entry_i];
      default: begin
        tbl_rd_data_o[DMA_STAT_VALID] = valid_q[tbl_rd_entry_i];
        tbl_rd_data_o[DMA_STAT_IEN]   = ien_q[tbl_rd_entry_i];
        tbl_rd_data_o[DMA_STAT_DONE]  = done_q[tbl_rd_entry_i];
      end
    endcase
  end

  // Controller view
  assign sel_src_o = src_q[ctrl_sel_i];
  assign sel_dst_o = dst_q[ctrl_sel_i];
  assign sel_len_o = len_q[ctrl_sel_i];
  assign valid_o   = valid_q;
  assign irq_o     = done_q & ien_q;

  a_retire_valid: assert property (@(posedge clk) disable iff (rst)
    retire_en_i |-> valid_q[retire_entry_i])
    else $error("Retire of an entry that is not valid");

endmodule

// File: dma_ctrl.sv
// DMA transfer controller
// Picks the lowest valid entry, launches both masters, retires the entry
`timescale 1ns/1ps

module dma_ctrl (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [dma_pkg::DMA_ENTRIES-1:0]        valid_i,
  input  logic [dma_pkg::DMA_LEN_WIDTH-1:0]      sel_len_i,
  output logic [dma_pkg::DMA_PTR_WIDTH-1:0]      ctrl_sel_o,
  output logic                                   rd_start_o,
  output logic                                   wr_start_o,
  input  logic                                   wr_done_i,
  output logic                                   retire_en_o,
  output logic [dma_pkg::DMA_PTR_WIDTH-1:0]      retire_entry_o
);
  import dma_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LAUNCH,    // Selected entry visible on the table outputs
    ST_RUN
  } state_e;

  state_e                   state_q;
  logic [DMA_PTR_WIDTH-1:0] sel_q;
  logic [DMA_PTR_WIDTH-1:0] pick;
  logic                     zero_len;

  // Lowest index wins
  always_comb begin
    pick = '0;
    for (int i = DMA_ENTRIES - 1; i >= 0; i--) begin
      if (valid_i[i]) begin
        pick = DMA_PTR_WIDTH'(i);
      end
    end
  end

  assign zero_len = (sel_len_i == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      sel_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (|valid_i) begin
            sel_q   <= pick;
            state_q <= ST_LAUNCH;
          end
        end
        ST_LAUNCH: state_q <= zero_len ? ST_IDLE : ST_RUN;
        ST_RUN:    if (wr_done_i) state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // Both masters start together, empty entries skip the copy
  assign rd_start_o     = (state_q == ST_LAUNCH) & ~zero_len;
  assign wr_start_o     = (state_q == ST_LAUNCH) & ~zero_len;
  assign retire_en_o    = ((state_q == ST_LAUNCH) & zero_len) |
                          ((state_q == ST_RUN) & wr_done_i);
  assign retire_entry_o = sel_q;
  assign ctrl_sel_o     = sel_q;

endmodule

// File: dma_read_master.sv
// DMA read master
// Fetches source words one at a time and pushes them into the FIFO
`timescale 1ns/1ps

module dma_read_master (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   start_i,
  input  logic [dma_pkg::DMA_ADDR_WIDTH-1:0]     src_i,
  input  logic [dma_pkg::DMA_LEN_WIDTH-1:0]      len_i,
  input  logic                                   fifo_full_i,
  output logic                                   fifo_push_o,
  output logic [dma_pkg::DMA_DATA_WIDTH-1:0]     fifo_wdata_o,
  output logic                                   m_cyc_o,
  output logic                                   m_stb_o,
  output logic                                   m_we_o,
  output logic [dma_pkg::DMA_ADDR_WIDTH-1:0]     m_adr_o,
  input  logic                                   m_ack_i,
  input  logic [dma_pkg::DMA_DATA_WIDTH-1:0]     m_dat_i
);
  import dma_pkg::*;

  logic                      cyc_q;
  logic [DMA_ADDR_WIDTH-1:0] adr_q;
  logic [DMA_LEN_WIDTH-1:0]  remain_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      cyc_q    <= 1'b0;
      remain_q <= '0;
    end else if (start_i) begin
      remain_q <= len_i;
    end else if (cyc_q) begin
      if (m_ack_i) begin
        cyc_q    <= 1'b0;    // Idle cycle between words
        remain_q <= remain_q - 1'b1;
      end
    end else if (remain_q != '0 && !fifo_full_i) begin
      cyc_q <= 1'b1;    // Slot free for the returned word
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      adr_q <= src_i;
    end else if (cyc_q && m_ack_i) begin
      adr_q <= adr_q + DMA_ADDR_WIDTH'(4);
    end
  end

  assign m_cyc_o = cyc_q;
  assign m_stb_o = cyc_q;
  assign m_we_o  = 1'b0;
  assign m_adr_o = adr_q;

  assign fifo_push_o  = cyc_q & m_ack_i;
  assign fifo_wdata_o = m_dat_i;

endmodule

// File: dma_word_fifo.sv
// DMA word FIFO
// Circular buffer between the read and the write master
`timescale 1ns/1ps

module dma_word_fifo #(
  parameter int DEPTH = dma_pkg::DMA_FIFO_DEPTH
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   push_i,
  input  logic [dma_pkg::DMA_DATA_WIDTH-1:0]     wdata_i,
  output logic                                   full_o,
  input  logic                                   pop_i,
  output logic [dma_pkg::DMA_DATA_WIDTH-1:0]     rdata_o,
  output logic                                   empty_o
);
  import dma_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [DMA_DATA_WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0]          wr_ptr_q;
  logic [PTR_W-1:0]          rd_ptr_q;
  logic [CNT_W-1:0]          count_q;

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push_i && !pop_i) count_q <= count_q + 1'b1;
      if (pop_i && !push_i) count_q <= count_q - 1'b1;
    end
  end

  assign rdata_o = mem[rd_ptr_q];    // Head word, first-word fall-through
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    push_i |-> !full_o)
    else $error("Push into a full FIFO");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    pop_i |-> !empty_o)
    else $error("Pop from an empty FIFO");

endmodule

// File: dma_write_master.sv
// DMA write master
// Drains the FIFO to the destination, one word per bus cycle
`timescale 1ns/1ps

module dma_write_master (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   start_i,
  input  logic [dma_pkg::DMA_ADDR_WIDTH-1:0]     dst_i,
  input  logic [dma_pkg::DMA_LEN_WIDTH-1:0]      len_i,
  input  logic                                   fifo_empty_i,
  input  logic [dma_pkg::DMA_DATA_WIDTH-1:0]     fifo_rdata_i,
  output logic                                   fifo_pop_o,
  output logic                                   done_o,
  output logic                                   m_cyc_o,
  output logic                                   m_stb_o,
  output logic                                   m_we_o,
  output logic [dma_pkg::DMA_ADDR_WIDTH-1:0]     m_adr_o,
  output logic [dma_pkg::DMA_DATA_WIDTH-1:0]     m_dat_o,
  input  logic                                   m_ack_i
);
  import dma_pkg::*;

  logic                      cyc_q;
  logic                      done_q;
  logic [DMA_ADDR_WIDTH-1:0] adr_q;
  logic [DMA_LEN_WIDTH-1:0]  remain_q;
  logic                      beat_done;

  assign beat_done = cyc_q & m_ack_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      cyc_q    <= 1'b0;
      done_q   <= 1'b0;
      remain_q <= '0;
    end else begin
      done_q <= beat_done && (remain_q == DMA_LEN_WIDTH'(1));    // Last word
      if (start_i) begin
        remain_q <= len_i;
      end else if (cyc_q) begin
        if (m_ack_i) begin
          cyc_q    <= 1'b0;
          remain_q <= remain_q - 1'b1;
        end
      end else if (remain_q != '0 && !fifo_empty_i) begin
        cyc_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_i) begin
      adr_q <= dst_i;
    end else if (beat_done) begin
      adr_q <= adr_q + DMA_ADDR_WIDTH'(4);
    end
  end

  assign m_cyc_o = cyc_q;
  assign m_stb_o = cyc_q;
  assign m_we_o  = 1'b1;
  assign m_adr_o = adr_q;
  assign m_dat_o = fifo_rdata_i;    // Head word held until the pop

  assign fifo_pop_o = beat_done;
  assign done_o     = done_q;

endmodule

// File: dma_bus_arb.sv
// DMA bus arbiter
// Shares the Wishbone master bus between the read and the write master
`timescale 1ns/1ps

module dma_bus_arb (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   rd_cyc_i,
  input  logic                                   rd_stb_i,
  input  logic                                   rd_we_i,
  input  logic [dma_pkg::DMA_ADDR_WIDTH-1:0]     rd_adr_i,
  output logic                                   rd_ack_o,
  output logic [dma_pkg::DMA_DATA_WIDTH-1:0]     rd_dat_o,
  input  logic                                   wr_cyc_i,
  input  logic                                   wr_stb_i,
  input  logic                                   wr_we_i,
  input  logic [dma_pkg::DMA_ADDR_WIDTH-1:0]     wr_adr_i,
  input  logic [dma_pkg::DMA_DATA_WIDTH-1:0]     wr_dat_i,
  output logic                                   wr_ack_o,
  output logic                                   bus_cyc_o,
  output logic                                   bus_stb_o,
  output logic                                   bus_we_o,
  output logic [dma_pkg::DMA_ADDR_WIDTH-1:0]     bus_adr_o,
  output logic [dma_pkg::DMA_DATA_WIDTH-1:0]     bus_dat_o,
  input  logic                                   bus_ack_i,
  input  logic [dma_pkg::DMA_DATA_WIDTH-1:0]     bus_dat_i
);

  logic gnt_wr_q;    // 1 selects the write master
  logic gnt_wr_nxt;
  logic active;

  assign active = gnt_wr_q ? wr_cyc_i : rd_cyc_i;

  ////////////////////////////////////////
  // Grant held for the whole bus cycle
  always_comb begin
    gnt_wr_nxt = gnt_wr_q;
    if (!active) begin
      if (wr_cyc_i) begin
        gnt_wr_nxt = 1'b1;    // Writer first since it frees FIFO space
      end else if (rd_cyc_i) begin
        gnt_wr_nxt = 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      gnt_wr_q <= 1'b1;
    end else begin
      gnt_wr_q <= gnt_wr_nxt;
    end
  end

  ////////////////////////////////////////
  // Request mux and ack routing
  assign bus_cyc_o = gnt_wr_q ? wr_cyc_i : rd_cyc_i;
  assign bus_stb_o = gnt_wr_q ? wr_stb_i : rd_stb_i;
  assign bus_we_o  = gnt_wr_q ? wr_we_i  : rd_we_i;
  assign bus_adr_o = gnt_wr_q ? wr_adr_i : rd_adr_i;
  assign bus_dat_o = gnt_wr_q ? wr_dat_i : '0;

  assign wr_ack_o = gnt_wr_q & bus_ack_i;
  assign rd_ack_o = ~gnt_wr_q & bus_ack_i;
  assign rd_dat_o = bus_dat_i;

  // An ack must still find its master on the bus
  a_ack_owner: assert property (@(posedge clk) disable iff (rst)
    bus_ack_i |-> active)
    else $error("Bus ack while the granted master is idle");

endmodule

// File: dma_top.sv
// DMA engine top level
// Host port, request table, controller, two bus masters, FIFO and arbiter
`timescale 1ns/1ps

module dma_top (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   cfg_cyc_i,
  input  logic                                   cfg_stb_i,
  input  logic                                   cfg_we_i,
  input  logic [dma_pkg::DMA_ADDR_WIDTH-1:0]     cfg_adr_i,
  input  logic [dma_pkg::DMA_DATA_WIDTH-1:0]     cfg_dat_i,
  output logic [dma_pkg::DMA_DATA_WIDTH-1:0]     cfg_dat_o,
  output logic                                   cfg_ack_o,
  output logic                                   bus_cyc_o,
  output logic                                   bus_stb_o,
  output logic                                   bus_we_o,
  output logic [dma_pkg::DMA_ADDR_WIDTH-1:0]     bus_adr_o,
  output logic [dma_pkg::DMA_DATA_WIDTH-1:0]     bus_dat_o,
  input  logic                                   bus_ack_i,
  input  logic [dma_pkg::DMA_DATA_WIDTH-1:0]     bus_dat_i,
  output logic [dma_pkg::DMA_ENTRIES-1:0]        irq_o
);
  import dma_pkg::*;

  // Host side to table
  logic                      tbl_wr_en;
  logic [DMA_PTR_WIDTH-1:0]  tbl_wr_entry, tbl_rd_entry;
  logic [DMA_REG_WIDTH-1:0]  tbl_wr_reg, tbl_rd_reg;
  logic [DMA_DATA_WIDTH-1:0] tbl_wr_data, tbl_rd_data;

  // Table to controller and masters
  logic [DMA_PTR_WIDTH-1:0]  ctrl_sel, retire_entry;
  logic [DMA_ADDR_WIDTH-1:0] sel_src, sel_dst;
  logic [DMA_LEN_WIDTH-1:0]  sel_len;
  logic [DMA_ENTRIES-1:0]    valid;
  logic                      retire_en, rd_start, wr_start, wr_done;

  // FIFO
  logic                      fifo_push, fifo_pop, fifo_full, fifo_empty;
  logic [DMA_DATA_WIDTH-1:0] fifo_wdata, fifo_rdata;

  // Master requests
  logic                      rd_cyc, rd_stb, rd_we, rd_ack;
  logic                      wr_cyc, wr_stb, wr_we, wr_ack;
  logic [DMA_ADDR_WIDTH-1:0] rd_adr, wr_adr;
  logic [DMA_DATA_WIDTH-1:0] rd_dat, wr_dat;

  dma_cfg_wb u_cfg (
    .clk, .rst,
    .cfg_cyc_i, .cfg_stb_i, .cfg_we_i, .cfg_adr_i, .cfg_dat_i, .cfg_dat_o, .cfg_ack_o,
    .tbl_wr_en_o    (tbl_wr_en),
    .tbl_wr_entry_o (tbl_wr_entry),
    .tbl_wr_reg_o   (tbl_wr_reg),
    .tbl_wr_data_o  (tbl_wr_data),
    .tbl_rd_entry_o (tbl_rd_entry),
    .tbl_rd_reg_o   (tbl_rd_reg),
    .tbl_rd_data_i  (tbl_rd_data)
  );

  dma_request_table u_table (
    .clk, .rst,
    .tbl_wr_en_i    (tbl_wr_en),
    .tbl_wr_entry_i (tbl_wr_entry),
    .tbl_wr_reg_i   (tbl_wr_reg),
    .tbl_wr_data_i  (tbl_wr_data),
    .tbl_rd_entry_i (tbl_rd_entry),
    .tbl_rd_reg_i   (tbl_rd_reg),
    .tbl_rd_data_o  (tbl_rd_data),
    .ctrl_sel_i     (ctrl_sel),
    .sel_src_o      (sel_src),
    .sel_dst_o      (sel_dst),
    .sel_len_o      (sel_len),
    .valid_o        (valid),
    .retire_en_i    (retire_en),
    .retire_entry_i (retire_entry),
    .irq_o
  );

  dma_ctrl u_ctrl (
    .clk, .rst,
    .valid_i        (valid),
    .sel_len_i      (sel_len),
    .ctrl_sel_o     (ctrl_sel),
    .rd_start_o     (rd_start),
    .wr_start_o     (wr_start),
    .wr_done_i      (wr_done),
    .retire_en_o    (retire_en),
    .retire_entry_o (retire_entry)
  );

  dma_read_master u_rd (
    .clk, .rst,
    .start_i (rd_start), .src_i (sel_src), .len_i (sel_len),
    .fifo_full_i (fifo_full), .fifo_push_o (fifo_push), .fifo_wdata_o (fifo_wdata),
    .m_cyc_o (rd_cyc), .m_stb_o (rd_stb), .m_we_o (rd_we), .m_adr_o (rd_adr),
    .m_ack_i (rd_ack), .m_dat_i (rd_dat)
  );

  dma_word_fifo #(.DEPTH(DMA_FIFO_DEPTH)) u_fifo (
    .clk, .rst,
    .push_i (fifo_push), .wdata_i (fifo_wdata), .full_o (fifo_full),
    .pop_i (fifo_pop), .rdata_o (fifo_rdata), .empty_o (fifo_empty)
  );

  dma_write_master u_wr (
    .clk, .rst,
    .start_i (wr_start), .dst_i (sel_dst), .len_i (sel_len),
    .fifo_empty_i (fifo_empty), .fifo_rdata_i (fifo_rdata), .fifo_pop_o (fifo_pop),
    .done_o (wr_done),
    .m_cyc_o (wr_cyc), .m_stb_o (wr_stb), .m_we_o (wr_we), .m_adr_o (wr_adr),
    .m_dat_o (wr_dat), .m_ack_i (wr_ack)
  );

  dma_bus_arb u_arb (
    .clk, .rst,
    .rd_cyc_i (rd_cyc), .rd_stb_i (rd_stb), .rd_we_i (rd_we), .rd_adr_i (rd_adr),
    .rd_ack_o (rd_ack), .rd_dat_o (rd_dat),
    .wr_cyc_i (wr_cyc), .wr_stb_i (wr_stb), .wr_we_i (wr_we), .wr_adr_i (wr_adr),
    .wr_dat_i (wr_dat), .wr_ack_o (wr_ack),
    .bus_cyc_o, .bus_stb_o, .bus_we_o, .bus_adr_o, .bus_dat_o, .bus_ack_i, .bus_dat_i
  );

endmodule

// File: tb_dma_top.sv
// DMA engine testbench
// Host accesses on the config port, a wait-state memory model on the bus port,
// directed copy tests checked against a reference copy of memory
`timescale 1ns/1ps

module tb_dma_top;
  import dma_pkg::*;

  localparam int MEM_WORDS      = 256;
  localparam int WAIT_SLOTS     = 64;
  localparam int TIMEOUT_CYCLES = 20000;    // Wide margin over all six tests

  logic                      clk;
  logic                      rst;
  logic                      cfg_cyc_i;
  logic                      cfg_stb_i;
  logic                      cfg_we_i;
  logic [DMA_ADDR_WIDTH-1:0] cfg_adr_i;
  logic [DMA_DATA_WIDTH-1:0] cfg_dat_i;
  logic [DMA_DATA_WIDTH-1:0] cfg_dat_o;
  logic                      cfg_ack_o;
  logic                      bus_cyc_o;
  logic                      bus_stb_o;
  logic                      bus_we_o;
  logic [DMA_ADDR_WIDTH-1:0] bus_adr_o;
  logic [DMA_DATA_WIDTH-1:0] bus_dat_o;
  logic                      bus_ack_i;
  logic [DMA_DATA_WIDTH-1:0] bus_dat_i;
  logic [DMA_ENTRIES-1:0]    irq_o;

  logic [31:0] mem [MEM_WORDS];        // Bus memory
  logic [31:0] ref_mem [MEM_WORDS];    // Expected contents
  int          wait_tab [WAIT_SLOTS];
  logic [5:0]  wait_pos;
  int          wait_left;
  bit          random_waits;
  int          access_count;
  int          errors;
  int          cycle_count;

  dma_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////
  // Memory model, one ack per request after 0 to 3 wait cycles
  always @(posedge clk) begin
    if (rst) begin
      bus_ack_i <= 1'b0;
      wait_left <= 0;
      wait_pos  <= '0;
    end else if (bus_ack_i) begin
      bus_ack_i <= 1'b0;    // Single-cycle ack
    end else if (bus_cyc_o && bus_stb_o) begin
      if (wait_left != 0) begin
        wait_left <= wait_left - 1;
      end else begin
        bus_ack_i <= 1'b1;
        if (bus_we_o) begin
          mem[bus_adr_o[9:2]] <= bus_dat_o;
        end else begin
          bus_dat_i <= mem[bus_adr_o[9:2]];
        end
        access_count <= access_count + 1;
        wait_left    <= random_waits ? wait_tab[wait_pos] : 0;    // Next request
        wait_pos     <= wait_pos + 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, a host access or a copy never finished",
               cycle_count);
      $display("TEST FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Helpers
  function automatic logic [31:0] fill_word(input int idx);
    logic [7:0] a;
    a = idx[7:0];
    return {8'hC5, a, ~a, a ^ 8'h3C};
  endfunction

  function automatic logic [31:0] reg_addr(input int entry, input logic [3:0] offset);
    return 32'(entry * 16) + 32'(offset);    // Bits 5:4 pick the entry
  endfunction

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("FAILED %s %s: expected 0x%08h, actual 0x%08h", test, what, exp, act);
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat);
    @(posedge clk);
    cfg_cyc_i <= 1'b1;
    cfg_stb_i <= 1'b1;
    cfg_we_i  <= 1'b1;
    cfg_adr_i <= adr;
    cfg_dat_i <= dat;
    do @(posedge clk); while (!cfg_ack_o);
    cfg_cyc_i <= 1'b0;
    cfg_stb_i <= 1'b0;
    cfg_we_i  <= 1'b0;
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
    @(posedge clk);
    cfg_cyc_i <= 1'b1;
    cfg_stb_i <= 1'b1;
    cfg_we_i  <= 1'b0;
    cfg_adr_i <= adr;
    do @(posedge clk); while (!cfg_ack_o);
    dat = cfg_dat_o;    // Valid with the ack
    cfg_cyc_i <= 1'b0;
    cfg_stb_i <= 1'b0;
  endtask

  task automatic load_descriptor(input int entry, input logic [31:0] src,
                                 input logic [31:0] dst, input logic [15:0] len);
    wb_write(reg_addr(entry, DMA_REG_SRC), src);
    wb_write(reg_addr(entry, DMA_REG_DST), dst);
    wb_write(reg_addr(entry, DMA_REG_LEN), 32'(len));
  endtask

  // Poll CTRL until done, the cycle counter bounds the wait
  task automatic wait_done(input int entry, output logic [31:0] status);
    status = '0;
    while (!status[DMA_STAT_DONE]) begin
      wb_read(reg_addr(entry, DMA_REG_CTRL), status);
    end
  endtask

  task automatic copy_reference(input logic [31:0] src, input logic [31:0] dst,
                                input int len);
    for (int i = 0; i < len; i++) begin
      ref_mem[dst[9:2] + i] = ref_mem[src[9:2] + i];
    end
  endtask

  task automatic compare_memory(input string test);
    for (int i = 0; i < MEM_WORDS; i++) begin
      if (mem[i] !== ref_mem[i]) report_mismatch(test, $sformatf("mem[%0d]", i),
                                                 ref_mem[i], mem[i]);
    end
  endtask

  ////////////////////////////////////////
  // Directed tests
  task automatic readback_registers();
    string       test;
    logic [31:0] rd;
    test = "register_readback";
    for (int e = 0; e < DMA_ENTRIES; e++) begin
      load_descriptor(e, 32'h1000_0011 | (e << 8), 32'h2000_0000 + e * 32'h44,
                      16'h0100 + 16'(e));
    end
    for (int e = 0; e < DMA_ENTRIES; e++) begin
      wb_read(reg_addr(e, DMA_REG_SRC), rd);
      if (rd !== (32'h1000_0011 | (e << 8))) report_mismatch(test, "SRC",
                                                            32'h1000_0011 | (e << 8), rd);
      wb_read(reg_addr(e, DMA_REG_DST), rd);
      if (rd !== 32'h2000_0000 + e * 32'h44) report_mismatch(test, "DST",
                                                            32'h2000_0000 + e * 32'h44, rd);
      wb_read(reg_addr(e, DMA_REG_LEN), rd);
      if (rd !== 32'h0100 + e) report_mismatch(test, "LEN", 32'h0100 + e, rd);
      wb_read(reg_addr(e, DMA_REG_CTRL), rd);
      if (rd !== 32'h0) report_mismatch(test, "CTRL", 32'h0, rd);
    end
  endtask

  task automatic copy_single_block();
    string       test;
    logic [31:0] status;
    test = "single_copy";
    random_waits = 1'b0;
    load_descriptor(0, 32'h000, 32'h200, 16'd8);
    copy_reference(32'h000, 32'h200, 8);
    wb_write(reg_addr(0, DMA_REG_CTRL), (1 << DMA_CTRL_START) | (1 << DMA_CTRL_IEN));
    wait_done(0, status);
    if (status !== ((1 << DMA_STAT_IEN) | (1 << DMA_STAT_DONE)))
      report_mismatch(test, "CTRL", (1 << DMA_STAT_IEN) | (1 << DMA_STAT_DONE), status);
    if (irq_o[0] !== 1'b1) report_mismatch(test, "irq_o[0]", 1, irq_o[0]);
    compare_memory(test);
  endtask

  task automatic copy_queued_entries();
    string       test;
    logic [31:0] status;
    test = "queued_entries";
    random_waits = 1'b0;
    load_descriptor(1, 32'h080, 32'h280, 16'd6);
    load_descriptor(2, 32'h0C0, 32'h2C0, 16'd5);
    copy_reference(32'h080, 32'h280, 6);
    copy_reference(32'h0C0, 32'h2C0, 5);
    wb_write(reg_addr(1, DMA_REG_CTRL), (1 << DMA_CTRL_START) | (1 << DMA_CTRL_IEN));
    wb_write(reg_addr(2, DMA_REG_CTRL), 1 << DMA_CTRL_START);
    wait_done(1, status);
    if (status !== ((1 << DMA_STAT_IEN) | (1 << DMA_STAT_DONE)))
      report_mismatch(test, "CTRL 1", (1 << DMA_STAT_IEN) | (1 << DMA_STAT_DONE), status);
    wait_done(2, status);
    if (status !== (1 << DMA_STAT_DONE))
      report_mismatch(test, "CTRL 2", 1 << DMA_STAT_DONE, status);
    if (irq_o[1] !== 1'b1) report_mismatch(test, "irq_o[1]", 1, irq_o[1]);
    if (irq_o[2] !== 1'b0) report_mismatch(test, "irq_o[2]", 0, irq_o[2]);
    compare_memory(test);
    // Start 0 acknowledges the interrupt
    wb_write(reg_addr(1, DMA_REG_CTRL), 32'h0);
    if (irq_o[1] !== 1'b0) report_mismatch(test, "irq_o[1] after clear", 0, irq_o[1]);
    wb_read(reg_addr(1, DMA_REG_CTRL), status);
    if (status !== 32'h0) report_mismatch(test, "CTRL 1 after clear", 32'h0, status);
  endtask

  task automatic copy_with_backpressure();
    string       test;
    logic [31:0] status;
    test = "back_pressure";
    random_waits = 1'b1;
    load_descriptor(0, 32'h040, 32'h300, 16'd12);    // Three FIFO depths
    copy_reference(32'h040, 32'h300, 12);
    wb_write(reg_addr(0, DMA_REG_CTRL), 1 << DMA_CTRL_START);
    wait_done(0, status);
    if (status !== (1 << DMA_STAT_DONE))
      report_mismatch(test, "CTRL", 1 << DMA_STAT_DONE, status);
    compare_memory(test);
    random_waits = 1'b0;
  endtask

  task automatic guard_busy_entry();
    string       test;
    logic [31:0] status;
    logic [31:0] rd;
    test = "busy_guard";
    random_waits = 1'b1;
    load_descriptor(3, 32'h100, 32'h340, 16'd8);
    copy_reference(32'h100, 32'h340, 8);
    wb_write(reg_addr(3, DMA_REG_CTRL), 1 << DMA_CTRL_START);
    wb_write(reg_addr(3, DMA_REG_DST), 32'h3A0);    // Entry still busy here
    wait_done(3, status);
    wb_read(reg_addr(3, DMA_REG_DST), rd);
    if (rd !== 32'h340) report_mismatch(test, "DST", 32'h340, rd);
    compare_memory(test);
    random_waits = 1'b0;
  endtask

  task automatic start_zero_length();
    string       test;
    logic [31:0] status;
    int          accesses_before;
    test = "zero_length";
    random_waits = 1'b0;
    load_descriptor(0, 32'h000, 32'h3E0, 16'd0);
    accesses_before = access_count;
    wb_write(reg_addr(0, DMA_REG_CTRL), 1 << DMA_CTRL_START);
    wait_done(0, status);
    if (status !== (1 << DMA_STAT_DONE))
      report_mismatch(test, "CTRL", 1 << DMA_STAT_DONE, status);
    if (access_count !== accesses_before)
      report_mismatch(test, "bus accesses", accesses_before, access_count);
    if (irq_o[0] !== 1'b0) report_mismatch(test, "irq_o[0]", 0, irq_o[0]);
    compare_memory(test);
  endtask

  ////////////////////////////////////////
  // Main sequence
  initial begin
    void'($urandom(37));
    for (int i = 0; i < WAIT_SLOTS; i++) begin
      wait_tab[i] = $urandom_range(3, 0);
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i]     = fill_word(i);
      ref_mem[i] = fill_word(i);
    end
    rst          = 1'b1;
    cfg_cyc_i    = 1'b0;
    cfg_stb_i    = 1'b0;
    cfg_we_i     = 1'b0;
    cfg_adr_i    = '0;
    cfg_dat_i    = '0;
    bus_ack_i    = 1'b0;
    bus_dat_i    = '0;
    random_waits = 1'b0;
    access_count = 0;
    errors       = 0;
    cycle_count  = 0;

    repeat (5) @(posedge clk);
    rst <= 1'b0;

    readback_registers();
    copy_single_block();
    copy_queued_entries();
    copy_with_backpressure();
    guard_busy_entry();
    start_zero_length();

    $display("Tests run: 6, errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: files.f
dma_pkg.sv
dma_cfg_wb.sv
dma_request_table.sv
dma_ctrl.sv
dma_read_master.sv
dma_word_fifo.sv
dma_write_master.sv
dma_bus_arb.sv
dma_top.sv
tb_dma_top.sv

// File: Bender.yml
package:
  name: dma_engine

sources:
  - dma_pkg.sv
  - dma_cfg_wb.sv
  - dma_request_table.sv
  - dma_ctrl.sv
  - dma_read_master.sv
  - dma_word_fifo.sv
  - dma_write_master.sv
  - dma_bus_arb.sv
  - dma_top.sv
  - target: test
    files:
      - tb_dma_top.sv
